// File: hw/i2s_defines.svh
`ifndef I2S_DEFINES_SVH
`define I2S_DEFINES_SVH

// bits carried in one audio sample.
`define I2S_SAMPLE_WIDTH 16

// slot length at which the bit counter stops counting.
`define I2S_MAX_SLOT_BITS 32

// flip-flops in each line synchronizer.
`define I2S_SYNC_STAGES 2

`endif

// File: hw/i2s_audio_pkg.sv
`default_nettype none

`include "i2s_defines.svh"

package i2s_audio_pkg;

    typedef logic [`I2S_SAMPLE_WIDTH-1:0] sample_t;

    // lrclk low selects the left channel.
    typedef enum logic {
        ch_left  = 1'b0,
        ch_right = 1'b1
    } channel_e;

endpackage

`default_nettype wire

// File: hw/i2s_link_pkg.sv
`default_nettype none

`include "i2s_defines.svh"

package i2s_link_pkg;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_left  = 2'd1,
        st_right = 2'd2
    } frame_state_e;

    // wide enough to hold a saturated count of the full slot.
    typedef logic [$clog2(`I2S_MAX_SLOT_BITS+1)-1:0] bit_count_t;

endpackage

`default_nettype wire

// File: hw/i2s_line_sync.sv
`default_nettype none

`include "i2s_defines.svh"

module i2s_line_sync #(
    parameter int sync_stages = `I2S_SYNC_STAGES
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    bclk,
    input  wire                    lrclk,
    input  wire                    adc_data,
    output logic                   bit_rise,
    output logic                   bit_fall,
    output logic                   lr_change,
    output i2s_audio_pkg::channel_e channel,
    output logic                   rx_bit
);

    // one chain per line, bit 2 bclk, bit 1 lrclk, bit 0 adc_data.
    logic [sync_stages-1:0][2:0] sync_q;
    logic bclk_s;
    logic lrclk_s;
    logic adc_s;
    logic bclk_dly;
    logic lr_latched;
    logic rise_w;
    logic fall_w;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= {bclk, lrclk, adc_data};
            for (int i = 1; i < sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign bclk_s  = sync_q[sync_stages-1][2];
    assign lrclk_s = sync_q[sync_stages-1][1];
    assign adc_s   = sync_q[sync_stages-1][0];

    assign rise_w = bclk_s & ~bclk_dly;
    assign fall_w = ~bclk_s & bclk_dly;

    ////////////////////////////////////////////////////////////////////////////
    // edge strobes, all registered so they line up with rx_bit.
    ////////////////////////////////////////////////////////////////////////////

    // the latched level starts high, so a leading right slot is not a change.
    always_ff @(posedge clk) begin
        if (reset) begin
            bclk_dly   <= 1'b0;
            lr_latched <= 1'b1;
            bit_rise   <= 1'b0;
            bit_fall   <= 1'b0;
            lr_change  <= 1'b0;
            channel    <= i2s_audio_pkg::ch_right;
            rx_bit     <= 1'b0;
        end else begin
            bclk_dly  <= bclk_s;
            bit_rise  <= rise_w;
            bit_fall  <= fall_w;
            lr_change <= rise_w & (lrclk_s != lr_latched);
            rx_bit    <= adc_s;
            if (rise_w) begin
                lr_latched <= lrclk_s;
                channel    <= i2s_audio_pkg::channel_e'(lrclk_s);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/i2s_frame_fsm.sv
`default_nettype none

`include "i2s_defines.svh"

module i2s_frame_fsm (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         lr_change,
    input  i2s_audio_pkg::channel_e     channel,
    input  i2s_link_pkg::bit_count_t    bit_count,
    output logic                        slot_start,
    output logic                        slot_end,
    output i2s_link_pkg::frame_state_e  state,
    output logic                        slot_short
);

    i2s_link_pkg::frame_state_e next_state;
    logic                       too_short;

    // the rise that changes lrclk still carries the last bit of the old slot,
    // so the slot length is one more than the count held so far.
    assign too_short = bit_count <
        i2s_link_pkg::bit_count_t'(`I2S_SAMPLE_WIDTH - 1);

    assign slot_start = lr_change;
    assign slot_end   = lr_change && (state != i2s_link_pkg::st_idle);

    always_comb begin
        next_state = state;
        if (lr_change) begin
            if (channel == i2s_audio_pkg::ch_left) begin
                next_state = i2s_link_pkg::st_left;
            end else begin
                next_state = i2s_link_pkg::st_right;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= i2s_link_pkg::st_idle;
            slot_short <= 1'b0;
        end else begin
            state      <= next_state;
            slot_short <= slot_end && too_short;
        end
    end

endmodule

`default_nettype wire

// File: hw/i2s_bit_counter.sv
`default_nettype none

`include "i2s_defines.svh"

module i2s_bit_counter (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       slot_start,
    input  wire                       bit_rise,
    output i2s_link_pkg::bit_count_t  bit_count
);

    logic at_max;

    assign at_max = (bit_count == i2s_link_pkg::bit_count_t'(`I2S_MAX_SLOT_BITS));

    // slot_start wins over the rise it arrives with, which
    // leaves that bit counted in the slot that is closing.
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= '0;
        end else if (slot_start) begin
            bit_count <= '0;
        end else if (bit_rise && !at_max) begin
            bit_count <= bit_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/i2s_rx_deser.sv
`default_nettype none

`include "i2s_defines.svh"

module i2s_rx_deser (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         bit_rise,
    input  wire                         rx_bit,
    input  wire                         slot_end,
    input  i2s_link_pkg::frame_state_e  state,
    output i2s_audio_pkg::sample_t      left_out,
    output i2s_audio_pkg::sample_t      right_out,
    output logic                        data_ready
);

    logic [`I2S_MAX_SLOT_BITS-1:0] shift_q;
    logic [`I2S_MAX_SLOT_BITS-1:0] shift_w;

    // the next shift value already holds the bit of this rise.
    assign shift_w = {shift_q[`I2S_MAX_SLOT_BITS-2:0], rx_bit};

    always_ff @(posedge clk) begin
        if (bit_rise) begin
            shift_q <= shift_w;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output words, latched when a slot closes.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            left_out   <= '0;
            right_out  <= '0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= 1'b0;
            if (slot_end) begin
                if (state == i2s_link_pkg::st_left) begin
                    left_out <= shift_w[`I2S_SAMPLE_WIDTH-1:0];
                end else if (state == i2s_link_pkg::st_right) begin
                    right_out  <= shift_w[`I2S_SAMPLE_WIDTH-1:0];
                    data_ready <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/i2s_tx_ser.sv
`default_nettype none

module i2s_tx_ser (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      slot_start,
    input  i2s_audio_pkg::channel_e  channel,
    input  wire                      bit_fall,
    input  i2s_audio_pkg::sample_t   left_in,
    input  i2s_audio_pkg::sample_t   right_in,
    output logic                     data_sampled,
    output logic                     dac_data
);

    i2s_audio_pkg::sample_t right_hold;
    i2s_audio_pkg::sample_t shift_q;

    // both words are taken together at the left slot start.
    always_ff @(posedge clk) begin
        if (slot_start && channel == i2s_audio_pkg::ch_left) begin
            right_hold <= right_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shifter, MSB out first, zero fill behind it.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q      <= '0;
            dac_data     <= 1'b0;
            data_sampled <= 1'b0;
        end else begin
            data_sampled <= 1'b0;
            if (slot_start) begin
                if (channel == i2s_audio_pkg::ch_left) begin
                    shift_q      <= left_in;
                    data_sampled <= 1'b1;
                end else begin
                    shift_q <= right_hold;
                end
            end else if (bit_fall) begin
                // first fall of a slot puts the MSB on the line.
                dac_data <= shift_q[$bits(shift_q)-1];
                shift_q  <= {shift_q[$bits(shift_q)-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/i2s_slave_port.sv
`default_nettype none

module i2s_slave_port (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     bclk,
    input  wire                     lrclk,
    input  wire                     adc_data,
    input  i2s_audio_pkg::sample_t  left_in,
    input  i2s_audio_pkg::sample_t  right_in,
    output i2s_audio_pkg::sample_t  left_out,
    output i2s_audio_pkg::sample_t  right_out,
    output logic                    data_ready,
    output logic                    data_sampled,
    output logic                    dac_data,
    output logic                    slot_short
);

    logic                       bit_rise;
    logic                       bit_fall;
    logic                       lr_change;
    logic                       rx_bit;
    logic                       slot_start;
    logic                       slot_end;
    i2s_audio_pkg::channel_e    channel;
    i2s_link_pkg::bit_count_t   bit_count;
    i2s_link_pkg::frame_state_e state;

    ////////////////////////////////////////////////////////////////////////////
    // line capture and slot tracking.
    ////////////////////////////////////////////////////////////////////////////

    i2s_line_sync u_line_sync (
        .clk       (clk),
        .reset     (reset),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .adc_data  (adc_data),
        .bit_rise  (bit_rise),
        .bit_fall  (bit_fall),
        .lr_change (lr_change),
        .channel   (channel),
        .rx_bit    (rx_bit)
    );

    i2s_frame_fsm u_frame_fsm (
        .clk        (clk),
        .reset      (reset),
        .lr_change  (lr_change),
        .channel    (channel),
        .bit_count  (bit_count),
        .slot_start (slot_start),
        .slot_end   (slot_end),
        .state      (state),
        .slot_short (slot_short)
    );

    i2s_bit_counter u_bit_counter (
        .clk        (clk),
        .reset      (reset),
        .slot_start (slot_start),
        .bit_rise   (bit_rise),
        .bit_count  (bit_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // data paths.
    ////////////////////////////////////////////////////////////////////////////

    i2s_rx_deser u_rx_deser (
        .clk        (clk),
        .reset      (reset),
        .bit_rise   (bit_rise),
        .rx_bit     (rx_bit),
        .slot_end   (slot_end),
        .state      (state),
        .left_out   (left_out),
        .right_out  (right_out),
        .data_ready (data_ready)
    );

    i2s_tx_ser u_tx_ser (
        .clk          (clk),
        .reset        (reset),
        .slot_start   (slot_start),
        .channel      (channel),
        .bit_fall     (bit_fall),
        .left_in      (left_in),
        .right_in     (right_in),
        .data_sampled (data_sampled),
        .dac_data     (dac_data)
    );

endmodule

`default_nettype wire

// File: verif/i2s_slave_port_assert.sv
`default_nettype none

module i2s_slave_port_assert (
    input wire                    clk,
    input wire                    reset,
    input wire                    data_ready,
    input wire                    data_sampled,
    input wire                    slot_short,
    input wire                    dac_data,
    input i2s_audio_pkg::sample_t left_out,
    input i2s_audio_pkg::sample_t right_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // each strobe is a single-cycle pulse.
    ready_one_cycle: assert property (
        @(posedge clk) disable iff (reset) data_ready |=> !data_ready
    ) else $error("data_ready held longer than one cycle");

    sampled_one_cycle: assert property (
        @(posedge clk) disable iff (reset) data_sampled |=> !data_sampled
    ) else $error("data_sampled held longer than one cycle");

    short_one_cycle: assert property (
        @(posedge clk) disable iff (reset) slot_short |=> !slot_short
    ) else $error("slot_short held longer than one cycle");

    ////////////////////////////////////////////////////////////////////////////
    // outputs settle to their idle values under reset.
    ////////////////////////////////////////////////////////////////////////////

    quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!data_ready && !data_sampled && !slot_short
            && !dac_data && left_out == '0 && right_out == '0)
    ) else $error("outputs not quiet while reset is high");

endmodule

bind i2s_slave_port i2s_slave_port_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .data_ready   (data_ready),
    .data_sampled (data_sampled),
    .slot_short   (slot_short),
    .dac_data     (dac_data),
    .left_out     (left_out),
    .right_out    (right_out)
);

`default_nettype wire

// File: verif/tb_i2s_slave_port.sv
`default_nettype none

`include "i2s_defines.svh"

module tb_i2s_slave_port;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_bclk = 6;
    localparam int sw = `I2S_SAMPLE_WIDTH;

    logic                   clk;
    logic                   reset;
    logic                   bclk;
    logic                   lrclk;
    logic                   adc_data;
    i2s_audio_pkg::sample_t left_in;
    i2s_audio_pkg::sample_t right_in;
    i2s_audio_pkg::sample_t left_out;
    i2s_audio_pkg::sample_t right_out;
    logic                   data_ready;
    logic                   data_sampled;
    logic                   dac_data;
    logic                   slot_short;

    // vector columns, one entry per stereo frame.
    logic [15:0] rx_left_q[$];
    logic [15:0] rx_right_q[$];
    logic [15:0] tx_left_q[$];
    logic [15:0] tx_right_q[$];
    int          len_q[$];

    logic [31:0] lcg_state = 32'd90455;
    logic [15:0] history = '0;
    logic        carry_bit = 1'b0;
    int          ready_count = 0;
    int          sampled_count = 0;
    int          short_count = 0;
    int          exp_ready = 0;
    int          exp_sampled = 0;
    int          exp_short = 0;
    logic [15:0] exp_left = '0;
    logic [15:0] exp_right = '0;
    int          prev_kind = 0;
    int          prev_len = 0;

    i2s_slave_port UUT (
        .clk          (clk),
        .reset        (reset),
        .bclk         (bclk),
        .lrclk        (lrclk),
        .adc_data     (adc_data),
        .left_in      (left_in),
        .right_in     (right_in),
        .left_out     (left_out),
        .right_out    (right_out),
        .data_ready   (data_ready),
        .data_sampled (data_sampled),
        .dac_data     (dac_data),
        .slot_short   (slot_short)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (data_ready) ready_count <= ready_count + 1;
            if (data_sampled) sampled_count <= sampled_count + 1;
            if (slot_short) short_count <= short_count + 1;
        end
    end

    function automatic logic next_filler_bit();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[16];
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_quiet();
        check_value("data_ready count", ready_count, 0);
        check_value("data_sampled count", sampled_count, 0);
        check_value("slot_short count", short_count, 0);
        check_value("dac_data", {31'd0, dac_data}, 0);
        check_value("left_out", {16'd0, left_out}, 0);
        check_value("right_out", {16'd0, right_out}, 0);
    endtask

    // waits for the pulses that close a slot, then pads out the bclk high half.
    task automatic settle_pulses();
        int waited;
        waited = 0;
        while ((ready_count != exp_ready || sampled_count != exp_sampled ||
                short_count != exp_short) && waited < half_bclk) begin
            @(negedge clk);
            waited++;
        end
        if (ready_count < exp_ready || sampled_count < exp_sampled ||
            short_count < exp_short) begin
            $display("timeout: slot end pulses did not arrive within half a bclk period");
            stop_on_failure();
        end
        repeat (half_bclk - waited) @(negedge clk);
        check_value("data_ready count", ready_count, exp_ready);
        check_value("data_sampled count", sampled_count, exp_sampled);
        check_value("slot_short count", short_count, exp_short);
        check_value("left_out", {16'd0, left_out}, {16'd0, exp_left});
        check_value("right_out", {16'd0, right_out}, {16'd0, exp_right});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one slot as the I2S master. kind 0 is the lead-in, 1 left, 2 right.
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_slot(input int kind, input int nbits, input logic [15:0] rx_word,
                             input logic [15:0] tx_word, input bit check_tx);
        logic bits [32];
        logic value;
        logic exp_dac;
        int   k;
        for (int i = 0; i < nbits; i++) begin
            if (nbits >= sw) begin
                bits[i] = (i < nbits - sw) ? next_filler_bit() : rx_word[nbits - 1 - i];
            end else begin
                bits[i] = rx_word[nbits - 1 - i];
            end
        end
        for (int j = 0; j < nbits; j++) begin
            // bit 0 of a slot time still belongs to the slot before.
            value = (j == 0) ? carry_bit : bits[j - 1];
            bclk = 1'b0;
            lrclk = (kind != 1);
            adc_data = value;
            history = {history[14:0], value};
            if (j == 0 && kind != 0) begin
                if (prev_kind != 0) begin
                    if (prev_len < sw) exp_short++;
                    if (prev_kind == 1) begin
                        exp_left = history;
                    end else begin
                        exp_right = history;
                        exp_ready++;
                    end
                end
                if (kind == 1) exp_sampled++;
            end
            repeat (half_bclk) @(negedge clk);
            k = j + 1;
            if (check_tx && k >= 2) begin
                exp_dac = (k <= sw + 1) ? tx_word[sw + 1 - k] : 1'b0;
                check_value("dac_data", {31'd0, dac_data}, {31'd0, exp_dac});
            end
            if (kind == 0) check_quiet();
            bclk = 1'b1;
            if (j == 0 && kind != 0) begin
                settle_pulses();
            end else begin
                repeat (half_bclk) @(negedge clk);
            end
        end
        carry_bit = bits[nbits - 1];
        prev_kind = kind;
        prev_len = nbits;
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] d;
        int          len;
        fd = $fopen("verif/i2s_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/i2s_vectors.txt");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %d", a, b, c, d, len);
            if (n == 5) begin
                rx_left_q.push_back(a);
                rx_right_q.push_back(b);
                tx_left_q.push_back(c);
                tx_right_q.push_back(d);
                len_q.push_back(len);
            end
        end
        $fclose(fd);
        if (len_q.size() == 0) begin
            $display("the vector file holds no frames");
            stop_on_failure();
        end
    endtask

    initial begin
        reset = 1'b1;
        bclk = 1'b0;
        lrclk = 1'b1;
        adc_data = 1'b0;
        left_in = '0;
        right_in = '0;
        load_vectors();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_quiet();

        send_slot(0, 32, 16'h0000, 16'h0000, 1'b0);
        for (int f = 0; f < len_q.size(); f++) begin
            left_in = tx_left_q[f];
            right_in = tx_right_q[f];
            send_slot(1, len_q[f], rx_left_q[f], tx_left_q[f], 1'b1);
            // inputs move on, so the right slot has to send the word held at left start.
            left_in = ~tx_left_q[f];
            right_in = ~tx_right_q[f];
            send_slot(2, len_q[f], rx_right_q[f], tx_right_q[f], 1'b1);
        end
        // a closing left slot ends the last right slot.
        left_in = '0;
        right_in = '0;
        send_slot(1, 32, 16'h0000, 16'h0000, 1'b1);

        check_value("data_ready count", ready_count, len_q.size());
        check_value("data_sampled count", sampled_count, len_q.size() + 1);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/i2s_vectors.txt
# rx_left rx_right tx_left tx_right slot_len (hex words, decimal length)
# slot_len applies to both slots of the frame; below 16 marks a short slot
a5c3 5a3c 8001 7ffe 32
1234 abcd f00f 0ff0 32
ffff 0000 0000 ffff 32
0f1e 2d3c c33c 3cc3 12
dead beef cafe babe 32
8000 0001 8000 0001 32
0755 0aaa 1357 2468 15
7e81 817e 9abc def0 32
00ff ff00 aaaa 5555 8
3c5a a5c3 4321 8765 32
1111 2222 3333 4444 32
fedc ba98 7654 3210 14
6b6b 9494 e1e1 1e1e 32
55aa aa55 0f0f f0f0 32

// File: tb.f
+incdir+hw
hw/i2s_audio_pkg.sv
hw/i2s_link_pkg.sv
hw/i2s_line_sync.sv
hw/i2s_frame_fsm.sv
hw/i2s_bit_counter.sv
hw/i2s_rx_deser.sv
hw/i2s_tx_ser.sv
hw/i2s_slave_port.sv
verif/i2s_slave_port_assert.sv
verif/tb_i2s_slave_port.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Ihw
TOP       = tb_i2s_slave_port
FILELIST  = tb.f

SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) hw/i2s_defines.svh
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

obj_dir/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
